//--- hdl/OramPkg.sv
//----------------------------------------------------------------------
// Shared widths and types for the Path ORAM stash.
// The top parameter ORAML must not exceed LeafWidth, since leafT is fixed.
//----------------------------------------------------------------------
`default_nettype none

package OramPkg;

	//----------------------------------------------------------------------
	// Defaults for the top-level parameters
	//----------------------------------------------------------------------

	// Leaf bits, also the tree depth below the root
	localparam int LeafWidth = 3;
	// Blocks per bucket
	localparam int DefaultZ = 2;
	// Stash entries
	localparam int DefaultCapacity = 16;

	//----------------------------------------------------------------------
	// Fixed widths
	//----------------------------------------------------------------------

	localparam int DataWidth = 32;
	localparam int PAddrWidth = 16;

	// Leaf label, bit 0 picks the child below the root
	typedef logic [LeafWidth-1:0] leafT;
	// Physical address, zero marks a dummy block
	typedef logic [PAddrWidth-1:0] pAddrT;
	// Block payload
	typedef logic [DataWidth-1:0] dataT;
	// Bucket level, 0 is the root, LeafWidth the leaf bucket
	typedef logic [$clog2(LeafWidth+1)-1:0] levelT;

	// One block as it travels on the path
	typedef struct packed {
		dataT data;
		pAddrT PAddr;
		leafT leaf;
	} blockT;

	// Access phases
	typedef enum logic [2:0] {
		PhIdle,
		PhPathRead,
		PhScan,
		PhWriteback,
		PhDone
	} phaseT;

endpackage

`default_nettype wire

//--- hdl/StashStore.sv
//----------------------------------------------------------------------
// Stash entry storage with lowest-free-slot allocation.
// A push while full is dropped here; the top flags the overflow.
// StashCapacity must be at least 2.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module StashStore #(
	parameter int StashCapacity = OramPkg::DefaultCapacity
) (
	input wire logic Clock,
	input wire logic reset,

	// Push of one real block
	input wire OramPkg::blockT PushBlock,
	input wire logic Push,

	// Removal of one entry after its transfer
	input wire logic [$clog2(StashCapacity)-1:0] RemoveSlot,
	input wire logic Remove,

	// Combinational read port
	input wire logic [$clog2(StashCapacity)-1:0] ReadSlot,
	output OramPkg::blockT SlotBlock,

	// Status
	output logic [StashCapacity-1:0] SlotValids,
	output logic [$clog2(StashCapacity+1)-1:0] Occupancy,
	output logic Full
);

	import OramPkg::*;

	localparam int SlotWidth = $clog2(StashCapacity);

	// Entry payloads, qualified by the valid vector
	blockT entries [StashCapacity];
	logic [StashCapacity-1:0] valids;

	// Lowest free slot
	logic [SlotWidth-1:0] freeSlot;
	logic pushAccepted;

	//----------------------------------------------------------------------
	// Free slot search and occupancy
	//----------------------------------------------------------------------

	// Priority encoder, lowest index wins
	always_comb begin
		freeSlot = '0;
		for (int i = StashCapacity - 1; i >= 0; i--) begin
			if (!valids[i])
				freeSlot = SlotWidth'(i);
		end
	end

	// Population count of the valid bits
	always_comb begin
		Occupancy = '0;
		for (int i = 0; i < StashCapacity; i++) begin
			if (valids[i])
				Occupancy = Occupancy + 1'b1;
		end
	end

	assign Full = &valids;
	// Block is lost when no slot is free
	assign pushAccepted = Push && !Full;

	//----------------------------------------------------------------------
	// Valid bits
	//----------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			valids <= '0;
		end else begin
			// Push and remove never hit the same slot
			if (pushAccepted)
				valids[freeSlot] <= 1'b1;
			if (Remove)
				valids[RemoveSlot] <= 1'b0;
		end
	end

	// Payload write
	always_ff @(posedge Clock) begin
		if (pushAccepted)
			entries[freeSlot] <= PushBlock;
	end

	//----------------------------------------------------------------------
	// Outputs
	//----------------------------------------------------------------------

	// Shared by scan and writeback, the top picks the index
	assign SlotBlock = entries[ReadSlot];
	assign SlotValids = valids;

endmodule

`default_nettype wire

//--- hdl/StashScanTable.sv
//----------------------------------------------------------------------
// Per-slot level table filled during scan, eligible-slot pick in writeback.
// Levels are meaningful only after a full scan of every slot.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module StashScanTable #(
	parameter int ORAML = OramPkg::LeafWidth,
	parameter int StashCapacity = OramPkg::DefaultCapacity
) (
	input wire logic Clock,
	input wire logic reset,

	// Leaf of the current access
	input wire OramPkg::leafT AccessLeaf,

	// One slot per scan step
	input wire logic ScanStep,
	input wire logic [$clog2(StashCapacity)-1:0] ScanSlot,
	input wire OramPkg::blockT ScanBlock,
	input wire logic ScanValid,

	// Writeback selection
	input wire OramPkg::levelT BucketLevel,
	input wire logic [StashCapacity-1:0] SlotValids,
	output logic [$clog2(StashCapacity)-1:0] SelectSlot,
	output logic SelectFound
);

	import OramPkg::*;

	localparam int SlotWidth = $clog2(StashCapacity);

	// Deepest legal level per slot
	levelT slotLevels [StashCapacity];
	// Slot held a real entry when it was scanned
	logic [StashCapacity-1:0] scanned;

	levelT scanLevel;

	//----------------------------------------------------------------------
	// Level computation
	//----------------------------------------------------------------------

	// Matching low-order leaf bits, stops at the first mismatch
	function automatic levelT matchLevel(input leafT blockLeaf, input leafT pathLeaf);
		levelT level;
		logic matching;
		level = '0;
		matching = 1'b1;
		for (int i = 0; i < ORAML; i++) begin
			if (matching && blockLeaf[i] == pathLeaf[i])
				level = level + 1'b1;
			else
				matching = 1'b0;
		end
		return level;
	endfunction

	// Capped at ORAML by the loop bound
	assign scanLevel = matchLevel(ScanBlock.leaf, AccessLeaf);

	always_ff @(posedge Clock) begin
		if (reset) begin
			scanned <= '0;
		end else if (ScanStep) begin
			scanned[ScanSlot] <= ScanValid;
		end
	end

	// Level storage
	always_ff @(posedge Clock) begin
		if (ScanStep)
			slotLevels[ScanSlot] <= scanLevel;
	end

	//----------------------------------------------------------------------
	// Writeback selection
	//----------------------------------------------------------------------

	// Lowest slot still valid whose level reaches the bucket
	always_comb begin
		SelectFound = 1'b0;
		SelectSlot = '0;
		for (int i = StashCapacity - 1; i >= 0; i--) begin
			if (SlotValids[i] && scanned[i] && slotLevels[i] >= BucketLevel) begin
				SelectFound = 1'b1;
				SelectSlot = SlotWidth'(i);
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/Stash.sv
//----------------------------------------------------------------------
// Path ORAM stash: path read, scan of every slot, greedy path writeback.
// Exactly BucketZ*(ORAML+1) write strobes per access; no LLC interface.
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module Stash #(
	parameter int ORAML = OramPkg::LeafWidth,
	parameter int BucketZ = OramPkg::DefaultZ,
	parameter int StashCapacity = OramPkg::DefaultCapacity
) (
	input wire logic Clock,
	input wire logic reset,

	// Access command
	input wire logic AccessStart,
	input wire OramPkg::leafT AccessLeaf,

	// Decrypted path blocks, no back-pressure
	input wire OramPkg::blockT WriteBlock,
	input wire logic WriteValid,

	// Writeback towards encryption and DRAM
	output OramPkg::blockT ReadBlock,
	output logic ReadValid,
	input wire logic ReadReady,

	// Completion and status
	output logic AccessDone,
	output logic StashAlmostFull,
	output logic StashOverflow
);

	import OramPkg::*;

	localparam int PathBlocks = BucketZ * (ORAML + 1);
	localparam int SlotWidth = $clog2(StashCapacity);
	localparam int CountWidth = $clog2(PathBlocks + 1);
	localparam int OccWidth = $clog2(StashCapacity + 1);

	phaseT phase, nextPhase;

	leafT accessLeafQ;
	logic [CountWidth-1:0] writeCount;
	logic [SlotWidth-1:0] scanSlot;
	logic [CountWidth-1:0] pathSlot;

	logic lastWrite, lastScan, lastPath;
	logic push, transfer;
	levelT bucketLevel;

	// Store and scan table wiring
	blockT slotBlock;
	logic [StashCapacity-1:0] slotValids;
	logic [OccWidth-1:0] occupancy;
	logic storeFull;
	logic [SlotWidth-1:0] readSlot;
	logic [SlotWidth-1:0] selectSlot;
	logic selectFound;

	//----------------------------------------------------------------------
	// Phase state machine
	//----------------------------------------------------------------------

	assign lastWrite = writeCount == CountWidth'(PathBlocks - 1);
	assign lastScan = scanSlot == SlotWidth'(StashCapacity - 1);
	assign lastPath = pathSlot == CountWidth'(PathBlocks - 1);
	assign transfer = ReadValid && ReadReady;

	always_comb begin
		nextPhase = phase;
		case (phase)
			PhIdle:
				if (AccessStart)
					nextPhase = PhPathRead;
			PhPathRead:
				if (WriteValid && lastWrite)
					nextPhase = PhScan;
			PhScan:
				if (lastScan)
					nextPhase = PhWriteback;
			PhWriteback:
				if (transfer && lastPath)
					nextPhase = PhDone;
			// One-cycle completion
			PhDone:
				nextPhase = PhIdle;
			default:
				nextPhase = PhIdle;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (reset)
			phase <= PhIdle;
		else
			phase <= nextPhase;
	end

	// Leaf is held for the whole access
	always_ff @(posedge Clock) begin
		if (phase == PhIdle && AccessStart)
			accessLeafQ <= AccessLeaf;
	end

	//----------------------------------------------------------------------
	// Path counters
	//----------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (reset) begin
			writeCount <= '0;
			scanSlot <= '0;
			pathSlot <= '0;
		end else begin
			// Strobes counted, dummies included
			if (phase == PhPathRead && WriteValid)
				writeCount <= lastWrite ? '0 : writeCount + 1'b1;
			if (phase == PhScan)
				scanSlot <= lastScan ? '0 : scanSlot + 1'b1;
			// Held while ReadReady is low
			if (transfer)
				pathSlot <= lastPath ? '0 : pathSlot + 1'b1;
		end
	end

	// Leaf bucket first, root last
	assign bucketLevel = levelT'(ORAML - int'(pathSlot) / BucketZ);

	//----------------------------------------------------------------------
	// Inbound path and status
	//----------------------------------------------------------------------

	// Dummies never reach the store
	assign push = phase == PhPathRead && WriteValid && WriteBlock.PAddr != '0;

	// Sticky until reset
	always_ff @(posedge Clock) begin
		if (reset)
			StashOverflow <= 1'b0;
		else if (push && storeFull)
			StashOverflow <= 1'b1;
	end

	// Not enough room left for another full path
	assign StashAlmostFull = int'(occupancy) > StashCapacity - PathBlocks;

	//----------------------------------------------------------------------
	// Storage and scan
	//----------------------------------------------------------------------

	// Read port follows the scan, then the selection
	assign readSlot = phase == PhScan ? scanSlot : selectSlot;

	StashStore #(
		.StashCapacity(StashCapacity)
	) i_StashStore (
		.Clock(Clock),
		.reset(reset),
		.PushBlock(WriteBlock),
		.Push(push),
		.RemoveSlot(selectSlot),
		.Remove(transfer && selectFound),
		.ReadSlot(readSlot),
		.SlotBlock(slotBlock),
		.SlotValids(slotValids),
		.Occupancy(occupancy),
		.Full(storeFull)
	);

	StashScanTable #(
		.ORAML(ORAML),
		.StashCapacity(StashCapacity)
	) i_StashScanTable (
		.Clock(Clock),
		.reset(reset),
		.AccessLeaf(accessLeafQ),
		.ScanStep(phase == PhScan),
		.ScanSlot(scanSlot),
		.ScanBlock(slotBlock),
		.ScanValid(slotValids[scanSlot]),
		.BucketLevel(bucketLevel),
		.SlotValids(slotValids),
		.SelectSlot(selectSlot),
		.SelectFound(selectFound)
	);

	//----------------------------------------------------------------------
	// Outbound path
	//----------------------------------------------------------------------

	// All-zero block doubles as the dummy
	assign ReadBlock = selectFound ? slotBlock : '0;
	assign ReadValid = phase == PhWriteback;
	assign AccessDone = phase == PhDone;

endmodule

`default_nettype wire

//--- testbench/Stash_assert.sv
//----------------------------------------------------------------------
// Handshake and phase checks bound into every Stash instance
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module Stash_assert (
	input wire logic Clock,
	input wire logic reset,
	input wire OramPkg::phaseT phase,
	input wire OramPkg::blockT ReadBlock,
	input wire logic ReadValid,
	input wire logic ReadReady,
	input wire logic AccessDone
);

	import OramPkg::*;

	// Offered block held until taken
	holdStable: assert property (@(posedge Clock) disable iff (reset)
		ReadValid && !ReadReady |=> ReadValid && $stable(ReadBlock))
		else $error("ReadBlock or ReadValid changed while ReadReady was low");

	// Completion strobe is a single cycle right after the last transfer
	doneOneCycle: assert property (@(posedge Clock) disable iff (reset)
		AccessDone |-> !$past(AccessDone) && $past(ReadValid && ReadReady))
		else $error("AccessDone not a single cycle right after a transfer");

	// Outbound path opens only after the scan
	validAfterScan: assert property (@(posedge Clock) disable iff (reset)
		$rose(ReadValid) |-> $past(phase) == PhScan)
		else $error("ReadValid rose without a preceding scan");

	// Outbound path closes only with a transfer, into completion
	validClosesOnTransfer: assert property (@(posedge Clock) disable iff (reset)
		$fell(ReadValid) |-> $past(ReadReady) && AccessDone)
		else $error("ReadValid fell without a final transfer and completion");

endmodule

`default_nettype wire

//--- testbench/StashTb.sv
//----------------------------------------------------------------------
// Stash testbench with default parameters, LFSR stimulus and a greedy model
// Writeback order checked against the reference and status after each access
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module StashTb;

	import OramPkg::*;

	localparam int ORAML = LeafWidth;
	localparam int BucketZ = DefaultZ;
	localparam int StashCapacity = DefaultCapacity;
	localparam int PathBlocks = BucketZ * (ORAML + 1);
	localparam int ResetCycles = 16;
	localparam int AccessCount = 12;
	localparam int AccessCycles = PathBlocks * 8 + StashCapacity + 20;

	logic Clock = 1'b0;
	logic reset, AccessStart, WriteValid, ReadReady;
	leafT AccessLeaf;
	blockT WriteBlock, ReadBlock;
	logic ReadValid, AccessDone, StashAlmostFull, StashOverflow;

	// Model of the stash content
	blockT modelBlocks [StashCapacity];
	logic [StashCapacity-1:0] modelValids;
	logic expectOverflow;
	blockT expectedQueue [$];
	logic [31:0] lfsrState = 32'hac421a46;

	// Compare process state
	int transferIndex = 0;
	int transferTotal = 0;
	logic doneExpected = 1'b0;

	Stash #(.ORAML(ORAML), .BucketZ(BucketZ), .StashCapacity(StashCapacity)) i_Stash (.*);

	bind Stash Stash_assert i_StashAssert (.Clock(Clock), .reset(reset), .phase(phase),
		.ReadBlock(ReadBlock), .ReadValid(ReadValid), .ReadReady(ReadReady),
		.AccessDone(AccessDone));

	always #4 Clock = ~Clock;

	//----------------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------------

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h80200003 : lfsrState >> 1;
		end
		return value;
	endfunction

	task automatic checkValue(input logic [63:0] got, input logic [63:0] expected,
		input string what);
		if (got !== expected) begin
			$display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display("Simulation failed");
			$fatal(1, "mismatch");
		end
	endtask

	// Deepest level on the path from the matching low leaf bits
	function automatic int leafLevel(input leafT blockLeaf, input leafT pathLeaf);
		int level;
		level = 0;
		while (level < ORAML && blockLeaf[level] == pathLeaf[level])
			level++;
		return level;
	endfunction

	// Model push into the lowest free slot
	function automatic void pushModel(input blockT block);
		if (block.PAddr == '0)
			return;
		if (&modelValids)
			expectOverflow = 1'b1;
		for (int i = 0; i < StashCapacity; i++) begin
			if (!modelValids[i]) begin
				modelBlocks[i] = block;
				modelValids[i] = 1'b1;
				break;
			end
		end
	endfunction

	// Reference writeback from the leaf bucket to the root
	function automatic void greedyWriteback(input leafT pathLeaf);
		blockT chosen;
		expectedQueue.delete();
		for (int p = 0; p < PathBlocks; p++) begin
			chosen = '0;
			for (int i = 0; i < StashCapacity; i++) begin
				if (modelValids[i]
					&& leafLevel(modelBlocks[i].leaf, pathLeaf) >= ORAML - p / BucketZ) begin
					chosen = modelBlocks[i];
					modelValids[i] = 1'b0;
					break;
				end
			end
			expectedQueue.push_back(chosen);
		end
	endfunction

	// Mode 0 shares the access leaf, 1 is random with dummies, 2 is root only
	task automatic runAccess(input int mode);
		leafT leaf;
		blockT block;
		int waitCycles;
		leaf = leafT'(randomBits(LeafWidth));
		// Root-only blocks never match any root-only access in bit 0
		if (mode == 2)
			leaf[0] = 1'b0;
		@(negedge Clock);
		AccessStart = 1'b1;
		AccessLeaf = leaf;
		@(negedge Clock);
		AccessStart = 1'b0;
		for (int i = 0; i < PathBlocks; i++) begin
			block.data = dataT'(randomBits(DataWidth));
			block.PAddr = pAddrT'(randomBits(PAddrWidth)) | pAddrT'(1);
			block.leaf = mode == 0 ? leaf : leafT'(randomBits(LeafWidth));
			if (mode == 1 && randomBits(2) == 0)
				block.PAddr = '0;
			if (mode == 2)
				block.leaf[0] = ~leaf[0];
			WriteBlock = block;
			WriteValid = 1'b1;
			pushModel(block);
			@(negedge Clock);
		end
		WriteValid = 1'b0;
		WriteBlock = '0;
		greedyWriteback(leaf);
		waitCycles = 0;
		// Random back-pressure until completion
		while (!AccessDone) begin
			if (waitCycles > AccessCycles) begin
				$display("AccessDone did not arrive within %0d cycles", AccessCycles);
				$display("Simulation failed");
				$fatal(1, "access timeout");
			end
			ReadReady = randomBits(1) != 0;
			waitCycles++;
			@(negedge Clock);
		end
		ReadReady = 1'b0;
		@(negedge Clock);
		checkValue(64'(StashAlmostFull),
			64'($countones(modelValids) > StashCapacity - PathBlocks), "StashAlmostFull");
		checkValue(64'(StashOverflow), 64'(expectOverflow), "StashOverflow");
	endtask

	//----------------------------------------------------------------------
	// Compare process sampling before the edge updates
	//----------------------------------------------------------------------

	always @(posedge Clock) begin
		if (!reset) begin
			checkValue(64'(AccessDone), 64'(doneExpected), "AccessDone");
			doneExpected = 1'b0;
			if (ReadValid && ReadReady) begin
				if (transferIndex >= expectedQueue.size()) begin
					$display("Read transfer at %0t ns with no block expected", $time);
					$display("Simulation failed");
					$fatal(1, "unexpected transfer");
				end
				checkValue(64'(ReadBlock), 64'(expectedQueue[transferIndex]), "ReadBlock");
				transferIndex++;
				transferTotal++;
				// Done must follow the last transfer
				if (transferIndex == PathBlocks) begin
					transferIndex = 0;
					doneExpected = 1'b1;
				end
			end
		end
	end

	initial begin
		repeat (ResetCycles + AccessCount * AccessCycles) @(posedge Clock);
		$display("Watchdog expired before all accesses completed");
		$display("Simulation failed");
		$fatal(1, "watchdog");
	end

	//----------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------

	initial begin
		reset = 1'b1;
		AccessStart = 1'b0;
		AccessLeaf = '0;
		WriteBlock = '0;
		WriteValid = 1'b0;
		ReadReady = 1'b0;
		modelValids = '0;
		expectOverflow = 1'b0;
		repeat (ResetCycles) @(negedge Clock);
		reset = 1'b0;
		checkValue(64'(ReadValid), 64'd0, "ReadValid after reset");
		checkValue(64'(AccessDone), 64'd0, "AccessDone after reset");
		checkValue(64'(StashOverflow), 64'd0, "StashOverflow after reset");
		checkValue(64'(StashAlmostFull), 64'd0, "StashAlmostFull after reset");
		// Empty stash gives arrival order
		runAccess(0);
		repeat (7) runAccess(1);
		// Leftovers pile up until overflow
		repeat (4) runAccess(2);
		if (transferTotal == AccessCount * PathBlocks && expectOverflow) begin
			$display("Simulation passed");
		end else begin
			$display("Only %0d transfers or no overflow seen", transferTotal);
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- OramStash.f
hdl/OramPkg.sv
hdl/StashStore.sv
hdl/StashScanTable.sv
hdl/Stash.sv
testbench/Stash_assert.sv
testbench/StashTb.sv

//--- run.sh
#!/bin/sh
# Builds the stash testbench with Verilator and runs it.
# Exit status is 0 only when the pass message appears in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module StashTb -f OramStash.f -o StashSim \
	&& ./obj_dir/StashSim | tee /dev/stderr | grep -q "Simulation passed" \
	&& exit 0 \
	|| exit 1
